/* include/rvviDefs_defs.svh */
// Shared widths, cause codes and tracked CSR addresses for the RVVI trace converter and its testbench
`ifndef RVVI_DEFS_SVH
`define RVVI_DEFS_SVH

// Data and order widths
`define RVVI_XLEN             32
`define RVVI_ORDER_W          64

// Trap, NMI and debug cause codes
// Instruction bus fault is raised outside the core
`define RVVI_CAUSE_IBUS_FAULT 6'd48
`define RVVI_CAUSE_NMI_LOAD   11'd1024
`define RVVI_CAUSE_NMI_STORE  11'd1025
`define RVVI_DBG_HALTREQ      3'd3

// Tracked CSRs
`define RVVI_NUM_TRACKED_CSR  8
`define RVVI_CSR_MSTATUS      12'h300
`define RVVI_CSR_MIE          12'h304
`define RVVI_CSR_MTVEC        12'h305
`define RVVI_CSR_MSCRATCH     12'h340
`define RVVI_CSR_MEPC         12'h341
`define RVVI_CSR_MCAUSE       12'h342
`define RVVI_CSR_MTVAL        12'h343
`define RVVI_CSR_DPC          12'h7B1

`endif

/* source/rvviPkg.sv */
// Record types shared by the trace converter units, imported where the trap, trace or CSR types are used
`default_nettype none

`include "rvviDefs_defs.svh"

package rvviPkg;

   // Trap info as presented by the formal interface port
   typedef struct packed {
      logic       trap;
      logic       exception;
      logic       debug;
      logic [5:0] exceptionCause;
      logic [2:0] debugCause;
      logic [1:0] causeType;
   } trapInfo_t;

   // Interrupt info, cause covers the NMI range
   typedef struct packed {
      logic        intr;
      logic        exception;
      logic        interrupt;
      logic [10:0] cause;
   } intrInfo_t;

   // One retirement as seen by the trace consumer
   typedef struct packed {
      logic [`RVVI_ORDER_W-1:0] order;
      logic [31:0]              insn;
      logic [`RVVI_XLEN-1:0]    pcRdata;
      logic [`RVVI_XLEN-1:0]    pcWdata;
      logic                     trap;
      logic                     intr;
      logic [1:0]               mode;
      logic [31:0]              xWb;
      logic [`RVVI_XLEN-1:0]    xWdata;
   } traceRec_t;

   typedef struct packed {
      logic [11:0]           addr;
      logic [`RVVI_XLEN-1:0] value;
      logic                  wb;
   } csrRec_t;

endpackage

`default_nettype wire

/* source/retireIf.sv */
// Carries one accepted retirement from the order tracker to the monitor, CSR merge and top level
`timescale 1ns/1ps
`default_nettype none

interface retireIf;
   import rvviPkg::*;

   // Accept is a single-cycle pulse, other fields are valid with it
   logic        accept;
   trapInfo_t   trap;
   intrInfo_t   intr;
   logic [2:0]  dbg;
   logic        dbgMode;
   logic [1:0]  nmip;

   modport src (
      output accept, trap, intr, dbg, dbgMode, nmip
   );

   modport dst (
      input accept, trap, intr, dbg, dbgMode, nmip
   );

endinterface

`default_nettype wire

/* source/traceStage.sv */
// Output register with a valid strobe, parameterized on the payload type for trace and CSR records
`timescale 1ns/1ps
`default_nettype none

module traceStage #(
   parameter type payload_t = logic
) (
   input  logic     rvvi,
   input  logic     arstN_i,
   input  logic     load_i,
   input  payload_t d_i,
   output payload_t q_o,
   output logic     valid_o
);

   // Valid is a one-cycle strobe per load
   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= load_i;
      end
   end

   // Payload holds its last value between loads
   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         q_o <= '0;
      end else if (load_i) begin
         q_o <= d_i;
      end
   end

endmodule

`default_nettype wire

/* source/orderTracker.sv */
// Accepts each retirement once per order number, counts them and drives the retirement interface
`timescale 1ns/1ps
`default_nettype none

`include "rvviDefs_defs.svh"

module orderTracker (
   input  logic                     rvvi,
   input  logic                     arstN_i,
   input  logic                     valid_i,
   input  logic [`RVVI_ORDER_W-1:0] order_i,
   input  rvviPkg::trapInfo_t       trap_i,
   input  rvviPkg::intrInfo_t       intr_i,
   input  logic [2:0]               dbg_i,
   input  logic                     dbgMode_i,
   input  logic [1:0]               nmip_i,
   retireIf.src                     retire,
   output logic [31:0]              retireCount_o
);
   import rvviPkg::*;

   logic [`RVVI_ORDER_W-1:0] lastOrder;
   logic                     seenFirst;

   // First valid after reset has nothing to compare against
   assign retire.accept  = valid_i && (!seenFirst || (order_i != lastOrder));
   assign retire.trap    = trap_i;
   assign retire.intr    = intr_i;
   assign retire.dbg     = dbg_i;
   assign retire.dbgMode = dbgMode_i;
   assign retire.nmip    = nmip_i;

   always_ff @(posedge rvvi) begin
      if (retire.accept) begin
         lastOrder <= order_i;
      end
   end

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         seenFirst     <= 1'b0;
         retireCount_o <= '0;
      end else if (retire.accept) begin
         seenFirst     <= 1'b1;
         retireCount_o <= retireCount_o + 32'd1;
      end
   end

   // An order presented again right after its acceptance is dropped
   repeatDropped: assert property (@(posedge rvvi) disable iff (!arstN_i)
      retire.accept |=> (!retire.accept || (order_i != $past(order_i))));

endmodule

`default_nettype wire

/* source/retireMonitor.sv */
// Tracks the halt-request, NMI and instruction bus fault event levels across accepted retirements
`timescale 1ns/1ps
`default_nettype none

`include "rvviDefs_defs.svh"

module retireMonitor (
   input  logic        rvvi,
   input  logic        arstN_i,
   retireIf.dst        retire,
   output logic        haltReq_o,
   output logic        nmi_o,
   output logic        instrBusFault_o,
   output logic [10:0] nmiCause_o
);
   import rvviPkg::*;

   logic haltHit;
   logic nmiCauseHit;
   logic nmiHit;
   logic ibusHit;

   ////////////////////
   // Event conditions
   ////////////////////

   // Debug entry caused by a halt request
   assign haltHit = (retire.dbg == `RVVI_DBG_HALTREQ) && retire.dbgMode;

   // Load or store bus error reported as an interrupt
   assign nmiCauseHit = retire.intr.intr && retire.intr.interrupt &&
                        ((retire.intr.cause == `RVVI_CAUSE_NMI_LOAD) ||
                         (retire.intr.cause == `RVVI_CAUSE_NMI_STORE));

   // Pending NMI also holds the level
   assign nmiHit = nmiCauseHit || retire.nmip[0];

   assign ibusHit = retire.trap.trap && retire.trap.exception &&
                    (retire.trap.exceptionCause == `RVVI_CAUSE_IBUS_FAULT);

   ////////////////////
   // Event levels
   ////////////////////

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         haltReq_o <= 1'b0;
      end else if (retire.accept) begin
         haltReq_o <= haltHit;
      end
   end

   // Cause is kept after NMI clears
   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         nmi_o      <= 1'b0;
         nmiCause_o <= '0;
      end else if (retire.accept) begin
         nmi_o <= nmiHit;
         if (nmiHit) begin
            nmiCause_o <= retire.intr.cause;
         end
      end
   end

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         instrBusFault_o <= 1'b0;
      end else if (retire.accept) begin
         instrBusFault_o <= ibusHit;
      end
   end

   // A cause-driven NMI must present a load or store cause on the next edge
   nmiCauseValid: assert property (@(posedge rvvi) disable iff (!arstN_i)
      (retire.accept && nmiCauseHit) |=>
         nmi_o && ((nmiCause_o == `RVVI_CAUSE_NMI_LOAD) ||
                   (nmiCause_o == `RVVI_CAUSE_NMI_STORE)));

endmodule

`default_nettype wire

/* source/csrMerge.sv */
// Forms the visible CSR value from write and read data and flags changes of the tracked CSRs
`timescale 1ns/1ps
`default_nettype none

`include "rvviDefs_defs.svh"

module csrMerge (
   input  logic                  rvvi,
   input  logic                  arstN_i,
   retireIf.dst                  retire,
   input  logic [11:0]           addr_i,
   input  logic [`RVVI_XLEN-1:0] wdata_i,
   input  logic [`RVVI_XLEN-1:0] wmask_i,
   input  logic [`RVVI_XLEN-1:0] rdata_i,
   output rvviPkg::csrRec_t      csr_o,
   output logic                  csrValid_o
);
   import rvviPkg::*;

   localparam int IdxW = $clog2(`RVVI_NUM_TRACKED_CSR);
   localparam logic [11:0] TrackedAddr [`RVVI_NUM_TRACKED_CSR] = '{
      `RVVI_CSR_MSTATUS, `RVVI_CSR_MIE,    `RVVI_CSR_MTVEC, `RVVI_CSR_MSCRATCH,
      `RVVI_CSR_MEPC,    `RVVI_CSR_MCAUSE, `RVVI_CSR_MTVAL, `RVVI_CSR_DPC
   };

   logic [`RVVI_XLEN-1:0]            value;
   logic                             hit;
   logic [IdxW-1:0]                  idx;
   logic                             wb;
   logic [`RVVI_XLEN-1:0]            shadow [`RVVI_NUM_TRACKED_CSR];
   logic [`RVVI_NUM_TRACKED_CSR-1:0] shadowValid;
   csrRec_t                          merged;

   // Written bits under the mask, read bits elsewhere
   assign value = (wdata_i & wmask_i) | (rdata_i & ~wmask_i);

   always_comb begin
      hit = 1'b0;
      idx = '0;
      for (int i = 0; i < `RVVI_NUM_TRACKED_CSR; i++) begin
         if (addr_i == TrackedAddr[i]) begin
            hit = 1'b1;
            idx = IdxW'(i);
         end
      end
   end

   // Never-written shadow counts as a change
   assign wb = hit && (!shadowValid[idx] || (value != shadow[idx]));

   always_ff @(posedge rvvi) begin
      if (retire.accept && hit) begin
         shadow[idx] <= value;
      end
   end

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         shadowValid <= '0;
      end else if (retire.accept && hit) begin
         shadowValid[idx] <= 1'b1;
      end
   end

   assign merged = '{addr: addr_i, value: value, wb: wb};

   traceStage #(
      .payload_t(csrRec_t)
   ) csrStage (
      .rvvi    (rvvi),
      .arstN_i (arstN_i),
      .load_i  (retire.accept),
      .d_i     (merged),
      .q_o     (csr_o),
      .valid_o (csrValid_o)
   );

endmodule

`default_nettype wire

/* source/rvviTraceTop.sv */
// Top level of the retirement-trace converter, plain ports from the formal port to the trace outputs
`timescale 1ns/1ps
`default_nettype none

`include "rvviDefs_defs.svh"

module rvviTraceTop (
   input  logic                     rvvi,
   input  logic                     arstN_i,
   input  logic                     rvfiValid_i,
   input  logic [`RVVI_ORDER_W-1:0] rvfiOrder_i,
   input  logic [31:0]              rvfiInsn_i,
   input  rvviPkg::trapInfo_t       rvfiTrap_i,
   input  rvviPkg::intrInfo_t       rvfiIntr_i,
   input  logic [1:0]               rvfiMode_i,
   input  logic [`RVVI_XLEN-1:0]    rvfiPcRdata_i,
   input  logic [`RVVI_XLEN-1:0]    rvfiPcWdata_i,
   input  logic [2:0]               rvfiDbg_i,
   input  logic                     rvfiDbgMode_i,
   input  logic [1:0]               rvfiNmip_i,
   input  logic                     gprWe_i,
   input  logic [4:0]               gprIdx_i,
   input  logic [`RVVI_XLEN-1:0]    gprWdata_i,
   input  logic [11:0]              csrAddr_i,
   input  logic [`RVVI_XLEN-1:0]    csrWdata_i,
   input  logic [`RVVI_XLEN-1:0]    csrWmask_i,
   input  logic [`RVVI_XLEN-1:0]    csrRdata_i,
   output logic                     traceValid_o,
   output rvviPkg::traceRec_t       trace_o,
   output logic                     csrValid_o,
   output rvviPkg::csrRec_t         csr_o,
   output logic                     haltReq_o,
   output logic                     nmi_o,
   output logic [10:0]              nmiCause_o,
   output logic                     instrBusFault_o,
   output logic [31:0]              retireCount_o
);
   import rvviPkg::*;

   retireIf retire ();

   logic [31:0]           xWb;
   logic [`RVVI_XLEN-1:0] xWdata;
   logic                  trapKept;
   traceRec_t             traceD;

   orderTracker orderTracker (
      .rvvi          (rvvi),
      .arstN_i       (arstN_i),
      .valid_i       (rvfiValid_i),
      .order_i       (rvfiOrder_i),
      .trap_i        (rvfiTrap_i),
      .intr_i        (rvfiIntr_i),
      .dbg_i         (rvfiDbg_i),
      .dbgMode_i     (rvfiDbgMode_i),
      .nmip_i        (rvfiNmip_i),
      .retire        (retire),
      .retireCount_o (retireCount_o)
   );

   retireMonitor retireMonitor (
      .rvvi            (rvvi),
      .arstN_i         (arstN_i),
      .retire          (retire),
      .haltReq_o       (haltReq_o),
      .nmi_o           (nmi_o),
      .instrBusFault_o (instrBusFault_o),
      .nmiCause_o      (nmiCause_o)
   );

   csrMerge csrMerge (
      .rvvi       (rvvi),
      .arstN_i    (arstN_i),
      .retire     (retire),
      .addr_i     (csrAddr_i),
      .wdata_i    (csrWdata_i),
      .wmask_i    (csrWmask_i),
      .rdata_i    (csrRdata_i),
      .csr_o      (csr_o),
      .csrValid_o (csrValid_o)
   );

   ////////////////////
   // Record assembly
   ////////////////////

   // Only the externally raised fetch fault is passed on as a trap
   assign trapKept = retire.trap.trap &&
                     (retire.trap.exceptionCause == `RVVI_CAUSE_IBUS_FAULT);

   // x0 writes are dropped
   assign xWb    = (gprWe_i && (gprIdx_i != 5'd0)) ? (32'd1 << gprIdx_i) : 32'd0;
   assign xWdata = (xWb != 32'd0) ? gprWdata_i : '0;

   assign traceD = '{
      order:   rvfiOrder_i,
      insn:    rvfiInsn_i,
      pcRdata: rvfiPcRdata_i,
      pcWdata: rvfiPcWdata_i,
      trap:    trapKept,
      intr:    retire.intr.intr,
      mode:    rvfiMode_i,
      xWb:     xWb,
      xWdata:  xWdata
   };

   traceStage #(
      .payload_t(traceRec_t)
   ) traceOut (
      .rvvi    (rvvi),
      .arstN_i (arstN_i),
      .load_i  (retire.accept),
      .d_i     (traceD),
      .q_o     (trace_o),
      .valid_o (traceValid_o)
   );

endmodule

`default_nettype wire

/* tb/tbRvviTrace.sv */
// Testbench for the trace converter that drives directed and LFSR retirements and checks every output
`timescale 1ns/1ps
`default_nettype none

`include "rvviDefs_defs.svh"

module tbRvviTrace;
   import rvviPkg::*;

   localparam int NumCycles = 300;
   // Stimulus length plus room for reset and drain
   localparam int TimeoutCycles = NumCycles + 100;
   localparam logic [11:0] TrackedCsr [`RVVI_NUM_TRACKED_CSR] = '{
      `RVVI_CSR_MSTATUS, `RVVI_CSR_MIE,    `RVVI_CSR_MTVEC, `RVVI_CSR_MSCRATCH,
      `RVVI_CSR_MEPC,    `RVVI_CSR_MCAUSE, `RVVI_CSR_MTVAL, `RVVI_CSR_DPC
   };

   logic                     rvvi;
   logic                     arstN_i;
   logic                     rvfiValid_i;
   logic [`RVVI_ORDER_W-1:0] rvfiOrder_i;
   logic [31:0]              rvfiInsn_i;
   trapInfo_t                rvfiTrap_i;
   intrInfo_t                rvfiIntr_i;
   logic [1:0]               rvfiMode_i;
   logic [`RVVI_XLEN-1:0]    rvfiPcRdata_i;
   logic [`RVVI_XLEN-1:0]    rvfiPcWdata_i;
   logic [2:0]               rvfiDbg_i;
   logic                     rvfiDbgMode_i;
   logic [1:0]               rvfiNmip_i;
   logic                     gprWe_i;
   logic [4:0]               gprIdx_i;
   logic [`RVVI_XLEN-1:0]    gprWdata_i;
   logic [11:0]              csrAddr_i;
   logic [`RVVI_XLEN-1:0]    csrWdata_i;
   logic [`RVVI_XLEN-1:0]    csrWmask_i;
   logic [`RVVI_XLEN-1:0]    csrRdata_i;
   logic                     traceValid_o;
   traceRec_t                trace_o;
   logic                     csrValid_o;
   csrRec_t                  csr_o;
   logic                     haltReq_o;
   logic                     nmi_o;
   logic [10:0]              nmiCause_o;
   logic                     instrBusFault_o;
   logic [31:0]              retireCount_o;

   // Reference state that runs one edge ahead of the DUT outputs
   logic [15:0]              lfsr;
   logic                     expTraceValid;
   logic                     expCsrValid;
   traceRec_t                expTrace;
   csrRec_t                  expCsr;
   logic                     expHalt;
   logic                     expNmi;
   logic [10:0]              expNmiCause;
   logic                     expIbf;
   logic [31:0]              expCount;
   logic                     seen;
   logic [`RVVI_ORDER_W-1:0] lastOrder;
   logic [`RVVI_XLEN-1:0]    shadow [`RVVI_NUM_TRACKED_CSR];
   logic                     shadowValid [`RVVI_NUM_TRACKED_CSR];
   int                       errors;
   int                       checks;
   int                       cycles;

   rvviTraceTop DUT (.*);

   initial begin
      rvvi = 1'b0;
      forever #5 rvvi = ~rvvi;
   end

   ////////////////////
   // Reference model
   ////////////////////

   // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         bits = {bits[30:0], fb};
      end
      return bits;
   endfunction

   function automatic int trackedIndex(input logic [11:0] addr);
      int found;
      found = -1;
      for (int k = 0; k < `RVVI_NUM_TRACKED_CSR; k++) begin
         if (TrackedCsr[k] == addr) begin
            found = k;
         end
      end
      return found;
   endfunction

   // Written bit where the mask is set and read bit elsewhere
   function automatic logic [31:0] mergeCsr(input logic [31:0] wdata, wmask, rdata);
      logic [31:0] merged;
      for (int b = 0; b < 32; b++) begin
         merged[b] = wmask[b] ? wdata[b] : rdata[b];
      end
      return merged;
   endfunction

   function automatic traceRec_t refTrace();
      traceRec_t rec;
      rec.order   = rvfiOrder_i;
      rec.insn    = rvfiInsn_i;
      rec.pcRdata = rvfiPcRdata_i;
      rec.pcWdata = rvfiPcWdata_i;
      rec.trap    = rvfiTrap_i.trap && (rvfiTrap_i.exceptionCause == `RVVI_CAUSE_IBUS_FAULT);
      rec.intr    = rvfiIntr_i.intr;
      rec.mode    = rvfiMode_i;
      rec.xWb     = '0;
      rec.xWdata  = '0;
      // x0 never shows up as a write
      if (gprWe_i && (gprIdx_i != 5'd0)) begin
         rec.xWb[gprIdx_i] = 1'b1;
         rec.xWdata        = gprWdata_i;
      end
      return rec;
   endfunction

   task automatic stepReference();
      logic        accept;
      logic        nmiByCause;
      int          idx;
      logic [31:0] value;
      accept        = rvfiValid_i && (!seen || (rvfiOrder_i != lastOrder));
      expTraceValid = accept;
      expCsrValid   = accept;
      if (accept) begin
         seen      = 1'b1;
         lastOrder = rvfiOrder_i;
         expCount  = expCount + 32'd1;
         expTrace  = refTrace();
         idx       = trackedIndex(csrAddr_i);
         value     = mergeCsr(csrWdata_i, csrWmask_i, csrRdata_i);
         expCsr.addr  = csrAddr_i;
         expCsr.value = value;
         expCsr.wb    = 1'b0;
         if (idx >= 0) begin
            expCsr.wb        = !shadowValid[idx] || (shadow[idx] != value);
            shadow[idx]      = value;
            shadowValid[idx] = 1'b1;
         end
         expHalt    = (rvfiDbg_i == `RVVI_DBG_HALTREQ) && rvfiDbgMode_i;
         nmiByCause = rvfiIntr_i.intr && rvfiIntr_i.interrupt &&
                      ((rvfiIntr_i.cause == `RVVI_CAUSE_NMI_LOAD) ||
                       (rvfiIntr_i.cause == `RVVI_CAUSE_NMI_STORE));
         expNmi     = nmiByCause || rvfiNmip_i[0];
         // Cause is only reloaded while NMI is raised
         if (expNmi) begin
            expNmiCause = rvfiIntr_i.cause;
         end
         expIbf = rvfiTrap_i.trap && rvfiTrap_i.exception &&
                  (rvfiTrap_i.exceptionCause == `RVVI_CAUSE_IBUS_FAULT);
      end
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic driveRetirement(input int i);
      logic [`RVVI_ORDER_W-1:0] prevOrder;
      logic [1:0]               sel;
      prevOrder   = rvfiOrder_i;
      rvfiValid_i = (randBits(2) != 32'd0) || (i < 6);
      if (randBits(2) != 32'd0) begin
         rvfiOrder_i = rvfiOrder_i + 64'd1;
      end
      rvfiInsn_i    = randBits(32);
      rvfiPcRdata_i = randBits(32);
      rvfiPcWdata_i = randBits(32);
      rvfiMode_i    = 2'(randBits(2));
      rvfiTrap_i    = 13'(randBits(13));
      if (randBits(1) != 32'd0) begin
         rvfiTrap_i.exceptionCause = `RVVI_CAUSE_IBUS_FAULT;
      end
      rvfiIntr_i = 14'(randBits(14));
      sel        = 2'(randBits(2));
      if (sel == 2'd0) begin
         rvfiIntr_i.cause = `RVVI_CAUSE_NMI_LOAD;
      end else if (sel == 2'd1) begin
         rvfiIntr_i.cause = `RVVI_CAUSE_NMI_STORE;
      end
      rvfiDbg_i = 3'(randBits(3));
      if (randBits(2) == 32'd0) begin
         rvfiDbg_i = `RVVI_DBG_HALTREQ;
      end
      rvfiDbgMode_i = 1'(randBits(1));
      rvfiNmip_i    = {1'(randBits(1)), randBits(3) == 32'd0};
      gprWe_i       = 1'(randBits(1));
      gprIdx_i      = 5'(randBits(5));
      if (randBits(3) == 32'd0) begin
         gprIdx_i = 5'd0;
      end
      gprWdata_i = randBits(32);
      csrAddr_i  = (randBits(2) != 32'd0) ? TrackedCsr[3'(randBits(3))] : 12'(randBits(12));
      csrWmask_i = randBits(32);
      // Small values repeat often, so unchanged CSRs occur
      csrWdata_i = (randBits(1) != 32'd0) ? randBits(32) : {30'd0, 2'(randBits(2))};
      csrRdata_i = (randBits(1) != 32'd0) ? randBits(32) : {30'd0, 2'(randBits(2))};
      // Directed retirements 1 to 4 always carry a new order
      if ((i >= 1) && (i <= 4)) begin
         rvfiOrder_i = prevOrder + 64'd1;
      end
      // Directed retirements at the start
      case (i)
         1: begin
            rvfiDbg_i     = `RVVI_DBG_HALTREQ;
            rvfiDbgMode_i = 1'b1;
         end
         2: begin
            rvfiIntr_i.intr      = 1'b1;
            rvfiIntr_i.interrupt = 1'b1;
            rvfiIntr_i.cause     = `RVVI_CAUSE_NMI_STORE;
            rvfiNmip_i           = 2'b00;
         end
         3: begin
            rvfiTrap_i.trap           = 1'b1;
            rvfiTrap_i.exception      = 1'b1;
            rvfiTrap_i.exceptionCause = `RVVI_CAUSE_IBUS_FAULT;
         end
         4: begin
            gprWe_i  = 1'b1;
            gprIdx_i = 5'd0;
         end
         5: rvfiOrder_i = prevOrder;
         default: ;
      endcase
   endtask

   task automatic noteMismatch(input string testName, input string expText, input string actText);
      errors = errors + 1;
      $display("MISMATCH %s: expected %s, actual %s", testName, expText, actText);
   endtask

   initial begin
      lfsr          = 16'd79;
      arstN_i       = 1'b0;
      rvfiValid_i   = 1'b0;
      rvfiOrder_i   = '0;
      rvfiInsn_i    = '0;
      rvfiTrap_i    = '0;
      rvfiIntr_i    = '0;
      rvfiMode_i    = '0;
      rvfiPcRdata_i = '0;
      rvfiPcWdata_i = '0;
      rvfiDbg_i     = '0;
      rvfiDbgMode_i = 1'b0;
      rvfiNmip_i    = '0;
      gprWe_i       = 1'b0;
      gprIdx_i      = '0;
      gprWdata_i    = '0;
      csrAddr_i     = '0;
      csrWdata_i    = '0;
      csrWmask_i    = '0;
      csrRdata_i    = '0;
      expTraceValid = 1'b0;
      expCsrValid   = 1'b0;
      expTrace      = '0;
      expCsr        = '0;
      expHalt       = 1'b0;
      expNmi        = 1'b0;
      expNmiCause   = '0;
      expIbf        = 1'b0;
      expCount      = '0;
      seen          = 1'b0;
      lastOrder     = '0;
      errors        = 0;
      checks        = 0;
      for (int k = 0; k < `RVVI_NUM_TRACKED_CSR; k++) begin
         shadow[k]      = '0;
         shadowValid[k] = 1'b0;
      end
      repeat (2) @(posedge rvvi);
      @(negedge rvvi);
      arstN_i = 1'b1;
      checks  = checks + 1;
      if ({traceValid_o, csrValid_o, haltReq_o, nmi_o, instrBusFault_o, nmiCause_o,
           retireCount_o} !== 48'd0) begin
         noteMismatch("T1 reset values", "all zero",
                      $sformatf("%b %b %b %b %b %h %h", traceValid_o, csrValid_o, haltReq_o,
                                nmi_o, instrBusFault_o, nmiCause_o, retireCount_o));
      end
      for (int i = 0; i < NumCycles; i++) begin
         @(negedge rvvi);
         driveRetirement(i);
         stepReference();
      end
      @(negedge rvvi);
      rvfiValid_i = 1'b0;
      stepReference();
      repeat (2) @(posedge rvvi);
      #3;
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   ////////////////////
   // Comparison
   ////////////////////

   // Outputs are sampled 2 ns after the rising edge and stimulus moves on the falling edge
   initial begin
      @(posedge arstN_i);
      forever begin
         @(posedge rvvi);
         #2;
         checks = checks + 9;
         if (traceValid_o !== expTraceValid) begin
            noteMismatch("T2 trace valid", $sformatf("%b", expTraceValid),
                         $sformatf("%b", traceValid_o));
         end
         if (retireCount_o !== expCount) begin
            noteMismatch("T2 retire count", $sformatf("%0d", expCount),
                         $sformatf("%0d", retireCount_o));
         end
         if (trace_o !== expTrace) begin
            noteMismatch("T3 trace record", $sformatf("%h", expTrace), $sformatf("%h", trace_o));
         end
         if (csrValid_o !== expCsrValid) begin
            noteMismatch("T4 CSR valid", $sformatf("%b", expCsrValid), $sformatf("%b", csrValid_o));
         end
         if (csr_o !== expCsr) begin
            noteMismatch("T4 CSR record", $sformatf("%h", expCsr), $sformatf("%h", csr_o));
         end
         if (haltReq_o !== expHalt) begin
            noteMismatch("T5 halt request", $sformatf("%b", expHalt), $sformatf("%b", haltReq_o));
         end
         if (nmi_o !== expNmi) begin
            noteMismatch("T5 NMI", $sformatf("%b", expNmi), $sformatf("%b", nmi_o));
         end
         if (nmiCause_o !== expNmiCause) begin
            noteMismatch("T5 NMI cause", $sformatf("%0d", expNmiCause),
                         $sformatf("%0d", nmiCause_o));
         end
         if (instrBusFault_o !== expIbf) begin
            noteMismatch("T5 instruction bus fault", $sformatf("%b", expIbf),
                         $sformatf("%b", instrBusFault_o));
         end
      end
   end

   initial begin
      cycles = 0;
      forever begin
         @(posedge rvvi);
         cycles = cycles + 1;
         if (cycles > TimeoutCycles) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
            $display("Checks run: %0d, errors: %0d", checks, errors);
            $display("FAIL: see errors above");
            $finish;
         end
      end
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
source/rvviPkg.sv
source/retireIf.sv
source/traceStage.sv
source/orderTracker.sv
source/retireMonitor.sv
source/csrMerge.sv
source/rvviTraceTop.sv
tb/tbRvviTrace.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, pass only if the pass line was printed
verilator --binary --timing --assert -f tb.f --top-module tbRvviTrace -o tbRvviTrace || exit 1
simOut="$(./obj_dir/tbRvviTrace)"
echo "$simOut"
echo "$simOut" | grep -qx "PASS: all tests" && echo "run.sh: simulation passed" || {
   echo "run.sh: simulation failed"
   exit 1
}
